/* hdl/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN            = 32;
    localparam int REG_ADDR_W      = 5;
    localparam int REG_COUNT       = 32;
    localparam int RAM_WORDS       = 256;
    localparam int RAM_ADDR_W      = $clog2(RAM_WORDS);
    localparam int BE_W            = XLEN / 8;
    localparam int MEM_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_W      = $clog2(MEM_WAIT_CYCLES + 1);

    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI,  OP_AUIPC, OP_JAL,  OP_JALR,
        OP_BEQ,  OP_BNE,   OP_BLT,  OP_BGE,  OP_BLTU, OP_BGEU,
        OP_LB,   OP_LH,    OP_LW,   OP_LBU,  OP_LHU,
        OP_SB,   OP_SH,    OP_SW,
        OP_ADDI, OP_SLTI,  OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI,  OP_SRAI,
        OP_ADD,  OP_SUB,   OP_SLL,  OP_SLT,  OP_SLTU,
        OP_XOR,  OP_SRL,   OP_SRA,  OP_OR,   OP_AND
    } exec_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_MEM,
        ST_WB
    } ctrl_state_e;

    typedef struct packed {
        exec_op_e              op;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } issue_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] npc;
    } redirect_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [BE_W-1:0] be;
        logic            we;
    } mem_req_t;

    function automatic logic op_is_load(exec_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic op_is_store(exec_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic logic op_is_mem(exec_op_e op);
        return op_is_load(op) || op_is_store(op);
    endfunction

    // Branches, stores and NOP leave the register file alone.
    function automatic logic op_writes_rd(exec_op_e op);
        return !(op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                            OP_SB, OP_SH, OP_SW});
    endfunction

endpackage

/* hdl/wait_timer.sv */
`timescale 1ns/1ns
module wait_timer (
    input  logic clk,
    input  logic rst,
    input  logic start_i,
    output logic expired_o
);
    import exec_pkg::*;

    logic [WAIT_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst) begin
            count <= '0;
        end else if (start_i) begin
            count <= WAIT_CNT_W'(MEM_WAIT_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired_o = count == WAIT_CNT_W'(1); // Last count of the window.

    a_no_restart: assert property (@(posedge clk) disable iff (!rst)
        start_i |-> count == '0)
        else $error("Timer started while counting.");

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns
module reg_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [exec_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [exec_pkg::REG_ADDR_W-1:0] rs2_i,
    output logic [exec_pkg::XLEN-1:0]       rd_data1_o,
    output logic [exec_pkg::XLEN-1:0]       rd_data2_o,
    input  exec_pkg::wb_t                   wb_i
);
    import exec_pkg::*;

    logic [XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin // x0 writes dropped.
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rd_data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
        rd_data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    end

endmodule

/* hdl/alu_branch.sv */
`timescale 1ns/1ns
module alu_branch (
    input  exec_pkg::issue_t          instr_i,
    input  logic [exec_pkg::XLEN-1:0] reg1_i,
    input  logic [exec_pkg::XLEN-1:0] reg2_i,
    output logic [exec_pkg::XLEN-1:0] result_o,
    output exec_pkg::redirect_t       redirect_o,
    output logic [exec_pkg::XLEN-1:0] mem_addr_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] reg1_imm;
    logic [4:0]      shamt_imm;
    logic [4:0]      shamt_reg;

    assign pc_imm    = instr_i.pc + instr_i.imm;
    assign pc_next   = instr_i.pc + 32'd4;
    assign reg1_imm  = reg1_i + instr_i.imm;
    assign shamt_imm = instr_i.imm[4:0];
    assign shamt_reg = reg2_i[4:0];

    always_comb begin
        result_o   = '0;
        redirect_o = '0;
        mem_addr_o = '0;
        case (instr_i.op)
            OP_LUI:   result_o = instr_i.imm;
            OP_AUIPC: result_o = pc_imm;
            OP_JAL: begin
                result_o   = pc_next;
                redirect_o = '{taken: 1'b1, npc: pc_imm};
            end
            OP_JALR: begin
                result_o   = pc_next;
                redirect_o = '{taken: 1'b1, npc: reg1_imm};
            end
            // Branches always redirect, to the target or the fall-through.
            OP_BEQ:  redirect_o = '{1'b1, (reg1_i == reg2_i) ? pc_imm : pc_next};
            OP_BNE:  redirect_o = '{1'b1, (reg1_i != reg2_i) ? pc_imm : pc_next};
            OP_BLT: begin
                redirect_o = '{1'b1, ($signed(reg1_i) < $signed(reg2_i)) ? pc_imm : pc_next};
            end
            OP_BGE: begin
                redirect_o = '{1'b1, ($signed(reg1_i) >= $signed(reg2_i)) ? pc_imm : pc_next};
            end
            OP_BLTU: redirect_o = '{1'b1, (reg1_i < reg2_i) ? pc_imm : pc_next};
            OP_BGEU: redirect_o = '{1'b1, (reg1_i >= reg2_i) ? pc_imm : pc_next};
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                mem_addr_o = reg1_imm;
            end
            OP_SB, OP_SH, OP_SW: begin
                mem_addr_o = reg1_imm;
                result_o   = reg2_i; // Store value.
            end
            OP_ADDI:  result_o = reg1_imm;
            OP_SLTI:  result_o = {31'd0, $signed(reg1_i) < $signed(instr_i.imm)};
            OP_SLTIU: result_o = {31'd0, reg1_i < instr_i.imm};
            OP_XORI:  result_o = reg1_i ^ instr_i.imm;
            OP_ORI:   result_o = reg1_i | instr_i.imm;
            OP_ANDI:  result_o = reg1_i & instr_i.imm;
            OP_SLLI:  result_o = reg1_i << shamt_imm;
            OP_SRLI:  result_o = reg1_i >> shamt_imm;
            OP_SRAI:  result_o = $unsigned($signed(reg1_i) >>> shamt_imm);
            OP_ADD:   result_o = reg1_i + reg2_i;
            OP_SUB:   result_o = reg1_i - reg2_i;
            OP_SLL:   result_o = reg1_i << shamt_reg;
            OP_SLT:   result_o = {31'd0, $signed(reg1_i) < $signed(reg2_i)};
            OP_SLTU:  result_o = {31'd0, reg1_i < reg2_i};
            OP_XOR:   result_o = reg1_i ^ reg2_i;
            OP_SRL:   result_o = reg1_i >> shamt_reg;
            OP_SRA:   result_o = $unsigned($signed(reg1_i) >>> shamt_reg);
            OP_OR:    result_o = reg1_i | reg2_i;
            OP_AND:   result_o = reg1_i & reg2_i;
            default: begin
                result_o = '0; // NOP.
            end
        endcase
    end

endmodule

/* hdl/load_store_unit.sv */
`timescale 1ns/1ns
module load_store_unit (
    input  exec_pkg::exec_op_e        op_i,
    input  logic [exec_pkg::XLEN-1:0] addr_i,
    input  logic [exec_pkg::XLEN-1:0] store_data_i,
    input  logic                      mem_strobe_i,
    input  logic [exec_pkg::XLEN-1:0] ram_rdata_i,
    output exec_pkg::mem_req_t        mem_req_o,
    output logic [exec_pkg::XLEN-1:0] load_data_o
);
    import exec_pkg::*;

    logic        is_byte;
    logic        is_half;
    logic        is_word;
    logic        misaligned;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign is_byte    = op_i inside {OP_LB, OP_LBU, OP_SB};
    assign is_half    = op_i inside {OP_LH, OP_LHU, OP_SH};
    assign is_word    = op_i inside {OP_LW, OP_SW};
    assign misaligned = (is_half && addr_i[0]) || (is_word && addr_i[1:0] != 2'b00);

    always_comb begin
        mem_req_o.addr = addr_i;
        mem_req_o.we   = op_is_store(op_i) && mem_strobe_i; // Write on the expiring cycle.
        if (is_byte) begin
            mem_req_o.wdata = {4{store_data_i[7:0]}};
            mem_req_o.be    = 4'b0001 << addr_i[1:0];
        end else if (is_half) begin
            mem_req_o.wdata = {2{store_data_i[15:0]}};
            mem_req_o.be    = addr_i[1] ? 4'b1100 : 4'b0011;
        end else begin
            mem_req_o.wdata = store_data_i;
            mem_req_o.be    = 4'b1111;
        end
    end

    assign ld_byte = ram_rdata_i[8*addr_i[1:0] +: 8];
    assign ld_half = addr_i[1] ? ram_rdata_i[31:16] : ram_rdata_i[15:0];

    always_comb begin
        case (op_i)
            OP_LB:   load_data_o = {{24{ld_byte[7]}}, ld_byte};
            OP_LBU:  load_data_o = {24'd0, ld_byte};
            OP_LH:   load_data_o = {{16{ld_half[15]}}, ld_half};
            OP_LHU:  load_data_o = {16'd0, ld_half};
            default: load_data_o = ram_rdata_i; // LW.
        endcase
    end

    // Checked once per access, when the FSM strobes the RAM.
    a_aligned: assert property (@(posedge mem_strobe_i) !misaligned)
        else $error("Misaligned access to %h.", addr_i);

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ns
module data_ram (
    input  logic                      clk,
    input  exec_pkg::mem_req_t        mem_req_i,
    output logic [exec_pkg::XLEN-1:0] rdata_o
);
    import exec_pkg::*;

    logic [XLEN-1:0]       mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_idx;

    assign word_idx = mem_req_i.addr[2 +: RAM_ADDR_W]; // Drop the byte offset.

    always_ff @(posedge clk) begin
        if (mem_req_i.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (mem_req_i.be[b]) begin
                    mem[word_idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[word_idx];

endmodule

/* hdl/exec_ctrl_fsm.sv */
`timescale 1ns/1ns
module exec_ctrl_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid_i,
    input  exec_pkg::issue_t          issue_i,
    input  logic                      timer_expired_i,
    input  logic [exec_pkg::XLEN-1:0] alu_result_i,
    input  exec_pkg::redirect_t       redirect_i,
    input  logic [exec_pkg::XLEN-1:0] load_data_i,
    output exec_pkg::issue_t          instr_o,
    output logic                      timer_start_o,
    output logic                      mem_strobe_o,
    output exec_pkg::wb_t             rf_wb_o,
    output exec_pkg::wb_t             wb_o,
    output exec_pkg::redirect_t       redirect_o,
    output logic                      done_o,
    output logic                      busy_o
);
    import exec_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        is_mem;
    logic        wb_cycle;

    assign is_mem   = op_is_mem(instr_o.op);
    assign wb_cycle = (state == ST_EXEC && !is_mem) || state == ST_WB;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (issue_valid_i) state_next = ST_EXEC;
            ST_EXEC: state_next = is_mem ? ST_MEM : ST_IDLE;
            ST_MEM:  if (timer_expired_i) state_next = ST_WB;
            ST_WB:   state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    assign timer_start_o = state == ST_EXEC && is_mem; // Arms timer on the way into ST_MEM.
    assign mem_strobe_o  = state == ST_MEM && timer_expired_i;

    assign rf_wb_o.we   = wb_cycle && op_writes_rd(instr_o.op);
    assign rf_wb_o.rd   = instr_o.rd;
    assign rf_wb_o.data = op_is_load(instr_o.op) ? load_data_i : alu_result_i;

    assign busy_o = state != ST_IDLE || done_o; // Held through the done cycle.

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= ST_IDLE;
            instr_o    <= '0;
            wb_o       <= '0;
            redirect_o <= '0;
            done_o     <= 1'b0;
        end else begin
            state  <= state_next;
            done_o <= wb_cycle;
            if (state == ST_IDLE && issue_valid_i) begin
                instr_o <= issue_i;
            end
            if (wb_cycle) begin
                wb_o       <= rf_wb_o;
                redirect_o <= redirect_i;
            end else begin
                wb_o.we          <= 1'b0; // Payload kept, strobes dropped.
                redirect_o.taken <= 1'b0;
            end
        end
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst)
        issue_valid_i |-> !busy_o)
        else $error("Issue strobe while busy.");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_o |=> !done_o)
        else $error("done_o longer than one cycle.");

endmodule

/* hdl/exec_top.sv */
`timescale 1ns/1ns
module exec_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid_i,
    input  exec_pkg::issue_t    issue_i,
    output exec_pkg::wb_t       wb_o,
    output exec_pkg::redirect_t redirect_o,
    output logic                done_o,
    output logic                busy_o
);
    import exec_pkg::*;

    issue_t          instr;
    wb_t             rf_wb;
    redirect_t       alu_redirect;
    mem_req_t        mem_req;
    logic            timer_start;
    logic            timer_expired;
    logic            mem_strobe;
    logic [XLEN-1:0] rd_data1;
    logic [XLEN-1:0] rd_data2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] ram_rdata;
    logic [XLEN-1:0] load_data;

    exec_ctrl_fsm u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .issue_valid_i   (issue_valid_i),
        .issue_i         (issue_i),
        .timer_expired_i (timer_expired),
        .alu_result_i    (alu_result),
        .redirect_i      (alu_redirect),
        .load_data_i     (load_data),
        .instr_o         (instr),
        .timer_start_o   (timer_start),
        .mem_strobe_o    (mem_strobe),
        .rf_wb_o         (rf_wb),
        .wb_o            (wb_o),
        .redirect_o      (redirect_o),
        .done_o          (done_o),
        .busy_o          (busy_o)
    );

    wait_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .start_i   (timer_start),
        .expired_o (timer_expired)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst        (rst),
        .rs1_i      (instr.rs1),
        .rs2_i      (instr.rs2),
        .rd_data1_o (rd_data1),
        .rd_data2_o (rd_data2),
        .wb_i       (rf_wb)
    );

    alu_branch u_alu (
        .instr_i    (instr),
        .reg1_i     (rd_data1),
        .reg2_i     (rd_data2),
        .result_o   (alu_result),
        .redirect_o (alu_redirect),
        .mem_addr_o (mem_addr)
    );

    load_store_unit u_lsu (
        .op_i         (instr.op),
        .addr_i       (mem_addr),
        .store_data_i (alu_result),
        .mem_strobe_i (mem_strobe),
        .ram_rdata_i  (ram_rdata),
        .mem_req_o    (mem_req),
        .load_data_o  (load_data)
    );

    data_ram u_ram (
        .clk       (clk),
        .mem_req_i (mem_req),
        .rdata_o   (ram_rdata)
    );

endmodule

/* verification/exec_ref_model.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

logic [XLEN-1:0] shadow_regs [REG_COUNT] = '{default: '0};
logic [7:0]      shadow_mem [RAM_WORDS*BE_W] = '{default: '0};
logic [31:0]     lfsr_state = 32'h16c;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val        = {val[30:0], fb};
    end
    return val;
endfunction

function automatic void ref_exec(input issue_t ins, output wb_t wb, output redirect_t rdr);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] res;
    logic        writes;
    logic        cond;
    logic        is_br;
    int unsigned ma;
    a      = shadow_regs[ins.rs1];
    b      = shadow_regs[ins.rs2];
    ea     = a + ins.imm;
    ma     = ea % (RAM_WORDS * BE_W);
    res    = '0;
    writes = 1'b1;
    cond   = 1'b0;
    rdr    = '0;
    is_br  = ins.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    case (ins.op)
        OP_LUI:   res = ins.imm;
        OP_AUIPC: res = ins.pc + ins.imm;
        OP_JAL, OP_JALR: begin
            res = ins.pc + 32'd4; // Link value.
            rdr = '{taken: 1'b1, npc: (ins.op == OP_JAL) ? ins.pc + ins.imm : ea};
        end
        OP_BEQ:   cond = a == b;
        OP_BNE:   cond = a != b;
        OP_BLT:   cond = $signed(a) < $signed(b);
        OP_BGE:   cond = $signed(a) >= $signed(b);
        OP_BLTU:  cond = a < b;
        OP_BGEU:  cond = a >= b;
        OP_LB:    res = 32'($signed(shadow_mem[ma]));
        OP_LBU:   res = 32'(shadow_mem[ma]);
        OP_LH:    res = 32'($signed({shadow_mem[ma+1], shadow_mem[ma]}));
        OP_LHU:   res = 32'({shadow_mem[ma+1], shadow_mem[ma]});
        OP_LW:    res = {shadow_mem[ma+3], shadow_mem[ma+2], shadow_mem[ma+1], shadow_mem[ma]};
        OP_SB, OP_SH, OP_SW: begin
            writes = 1'b0;
            for (int i = 0; i < (ins.op == OP_SB ? 1 : ins.op == OP_SH ? 2 : 4); i++) begin
                shadow_mem[ma + i] = b[8*i +: 8];
            end
        end
        OP_ADDI:  res = ea;
        OP_SLTI:  res = ($signed(a) < $signed(ins.imm)) ? 32'd1 : 32'd0;
        OP_SLTIU: res = (a < ins.imm) ? 32'd1 : 32'd0;
        OP_XORI:  res = a ^ ins.imm;
        OP_ORI:   res = a | ins.imm;
        OP_ANDI:  res = a & ins.imm;
        OP_SLLI:  res = a << ins.imm[4:0];
        OP_SRLI:  res = a >> ins.imm[4:0];
        OP_SRAI:  res = $signed(a) >>> ins.imm[4:0];
        OP_ADD:   res = a + b;
        OP_SUB:   res = a - b;
        OP_SLL:   res = a << b[4:0];
        OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
        OP_XOR:   res = a ^ b;
        OP_SRL:   res = a >> b[4:0];
        OP_SRA:   res = $signed(a) >>> b[4:0];
        OP_OR:    res = a | b;
        OP_AND:   res = a & b;
        default:  writes = 1'b0;
    endcase
    if (is_br) begin
        writes = 1'b0;
        rdr    = '{taken: 1'b1, npc: cond ? ins.pc + ins.imm : ins.pc + 32'd4};
    end
    if (writes && ins.rd != 5'd0) begin
        shadow_regs[ins.rd] = res;
    end
    wb = '{we: writes, rd: ins.rd, data: res};
endfunction

`endif

/* verification/exec_tb.sv */
`timescale 1ns/1ns
module exec_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int ALU_COUNT  = 80;
    localparam int NUM_INSTR  = 31 + 93 + ALU_COUNT + 25 + 62 + 3 + 8;
    localparam int TIMEOUT_NS = (NUM_INSTR * (4 + MEM_WAIT_CYCLES) + 100) * CLK_PERIOD;

    typedef struct packed {
        wb_t         wb;
        redirect_t   rdr;
        logic [31:0] issue_cycle;
        logic [31:0] latency;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        issue_valid_i;
    issue_t      issue_i;
    wb_t         wb_o;
    redirect_t   redirect_o;
    logic        done_o;
    logic        busy_o;
    logic [31:0] cycles = '0;
    logic        prev_done = 1'b0;
    expect_t     exp_q [$];
    int          errors;
    int          checks;
    int          issued;
    int          tests;
    int          mark_errors;
    int          mark_issued;
    exec_op_e    alu_ops [19] = '{OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                                  OP_SLLI, OP_SRLI, OP_SRAI, OP_ADD, OP_SUB, OP_SLL, OP_SLT,
                                  OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    exec_op_e    br_ops [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    int          br_rs1 [3] = '{6, 5, 6}; // Equal, less, greater (signed).
    int          br_rs2 [3] = '{7, 6, 5};

    `include "exec_ref_model.svh"

    exec_top DUT (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .wb_o          (wb_o),
        .redirect_o    (redirect_o),
        .done_o        (done_o),
        .busy_o        (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 32'd1;

    function automatic logic [31:0] sext12(input logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        errors++;
    endtask

    // Called 5 ns after a rising edge; returns once busy_o has dropped.
    task automatic send_instr(input exec_op_e op, input int rd, input int rs1, input int rs2,
                              input logic [31:0] imm, input logic [31:0] pc);
        issue_t    ins;
        wb_t       exp_wb;
        redirect_t exp_rdr;
        expect_t   exp_e;
        ins = '{op: op, pc: pc, rs1: 5'(rs1), rs2: 5'(rs2), rd: 5'(rd), imm: imm};
        ref_exec(ins, exp_wb, exp_rdr);
        exp_e.wb          = exp_wb;
        exp_e.rdr         = exp_rdr;
        exp_e.issue_cycle = cycles + 32'd1;
        exp_e.latency     = (op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
                                        OP_SB, OP_SH, OP_SW})
                            ? 32'(2 + MEM_WAIT_CYCLES) : 32'd1;
        exp_q.push_back(exp_e);
        issued++;
        issue_i       = ins;
        issue_valid_i = 1'b1;
        @(posedge clk);
        #5;
        issue_valid_i = 1'b0;
        if (busy_o !== 1'b1) begin
            report_mismatch("busy_o", 32'(busy_o), 32'd1);
        end
        while (busy_o) begin
            @(posedge clk);
            #5;
        end
        if (exp_q.size() != 0) begin
            $display("%0t ns: busy_o dropped before done_o for the last instruction", $time);
            errors++;
        end
    endtask

    // ADDI x0, xr, 0 shows xr on wb_o without touching the file.
    task automatic readback_reg(input int r);
        send_instr(OP_ADDI, 0, r, 0, 32'd0, 32'd0);
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("Test %0d %s: %0d instructions, %0d errors", tests, name,
                 issued - mark_issued, errors - mark_errors);
        mark_issued = issued;
        mark_errors = errors;
    endtask

    always @(negedge clk) begin : compare
        expect_t     e;
        logic [31:0] lat;
        if (rst && prev_done && busy_o !== 1'b0) begin
            report_mismatch("busy_o after done_o", 32'(busy_o), 32'd0);
        end
        prev_done = done_o;
        if (rst && done_o) begin
            if (exp_q.size() == 0) begin
                $display("[ERROR] %0t ns: done_o pulsed with no instruction in flight", $time);
                errors++;
            end else begin
                e   = exp_q.pop_front();
                lat = cycles - e.issue_cycle;
                checks++;
                if (lat != e.latency) begin
                    report_mismatch("done_o latency", lat, e.latency);
                end
                if (busy_o !== 1'b1) begin
                    report_mismatch("busy_o", 32'(busy_o), 32'd1);
                end
                if (wb_o.we !== e.wb.we) begin
                    report_mismatch("wb_o.we", 32'(wb_o.we), 32'(e.wb.we));
                end
                if (e.wb.we && wb_o.rd !== e.wb.rd) begin
                    report_mismatch("wb_o.rd", 32'(wb_o.rd), 32'(e.wb.rd));
                end
                if (e.wb.we && wb_o.data !== e.wb.data) begin
                    report_mismatch("wb_o.data", wb_o.data, e.wb.data);
                end
                if (redirect_o.taken !== e.rdr.taken) begin
                    report_mismatch("redirect_o.taken", 32'(redirect_o.taken),
                                    32'(e.rdr.taken));
                end
                if (e.rdr.taken && redirect_o.npc !== e.rdr.npc) begin
                    report_mismatch("redirect_o.npc", redirect_o.npc, e.rdr.npc);
                end
            end
        end
    end

    initial begin
        exec_op_e    op;
        logic [31:0] imm;
        rst           = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #5;
            if ({done_o, busy_o, wb_o.we, redirect_o.taken} !== 4'b0000) begin
                report_mismatch("{done_o,busy_o,wb_o.we,redirect_o.taken}",
                                32'({done_o, busy_o, wb_o.we, redirect_o.taken}), 32'd0);
            end
        end
        for (int r = 1; r < 32; r++) begin
            readback_reg(r);
        end
        test_done("reset");

        for (int r = 1; r < 32; r++) begin
            send_instr(OP_LUI, r, 0, 0, rand_bits(20) << 12, 32'd0);
            send_instr(OP_ADDI, r, r, 0, sext12(rand_bits(12)), 32'd0);
        end
        for (int r = 1; r < 32; r++) begin
            readback_reg(r);
        end
        test_done("reg_build");

        for (int i = 0; i < ALU_COUNT; i++) begin
            op  = alu_ops[rand_bits(5) % 19];
            imm = (op inside {OP_SLLI, OP_SRLI, OP_SRAI}) ? rand_bits(5) : sext12(rand_bits(12));
            send_instr(op, rand_bits(5), rand_bits(5), rand_bits(5), imm, rand_bits(30) << 2);
        end
        test_done("alu_random");

        send_instr(OP_ADDI, 5, 0, 0, 32'hFFFF_FFFB, 32'd0);
        send_instr(OP_ADDI, 6, 0, 0, 32'd7, 32'd0);
        send_instr(OP_ADDI, 7, 0, 0, 32'd7, 32'd0);
        foreach (br_ops[i]) begin
            for (int p = 0; p < 3; p++) begin
                imm = sext12(rand_bits(12)) & ~32'd1;
                send_instr(br_ops[i], 0, br_rs1[p], br_rs2[p], imm, rand_bits(30) << 2);
            end
        end
        send_instr(OP_JAL, 1, 0, 0, sext12(rand_bits(12)) & ~32'd1, rand_bits(30) << 2);
        send_instr(OP_JAL, 0, 0, 0, sext12(rand_bits(12)) & ~32'd1, rand_bits(30) << 2);
        send_instr(OP_JALR, 3, 6, 0, sext12(rand_bits(12)), rand_bits(30) << 2);
        send_instr(OP_JALR, 4, 5, 0, sext12(rand_bits(12)), rand_bits(30) << 2);
        test_done("branch_jump");

        for (int w = 0; w < 4; w++) begin
            send_instr(OP_SW, 0, 0, rand_bits(5), 32'h100 + 4 * w, 32'd0);
        end
        for (int l = 0; l < 4; l++) begin
            send_instr(OP_SB, 0, 0, rand_bits(5), 32'h104 + l, 32'd0);
        end
        send_instr(OP_SH, 0, 0, rand_bits(5), 32'h108, 32'd0);
        send_instr(OP_SH, 0, 0, rand_bits(5), 32'h10A, 32'd0);
        for (int w = 0; w < 4; w++) begin
            for (int l = 0; l < 4; l++) begin
                imm = 32'h100 + 4 * w + l;
                send_instr(OP_LB, rand_bits(5), 0, 0, imm, 32'd0);
                send_instr(OP_LBU, rand_bits(5), 0, 0, imm, 32'd0);
                if (l % 2 == 0) begin
                    send_instr(OP_LH, rand_bits(5), 0, 0, imm, 32'd0);
                    send_instr(OP_LHU, rand_bits(5), 0, 0, imm, 32'd0);
                end
            end
            send_instr(OP_LW, rand_bits(5), 0, 0, 32'h100 + 4 * w, 32'd0);
        end
        test_done("load_store");

        send_instr(OP_ADDI, 0, 1, 0, 32'd5, 32'd0);
        send_instr(OP_LUI, 0, 0, 0, 32'h1234_5000, 32'd0);
        readback_reg(0);
        test_done("x0_write");

        for (int i = 0; i < 4; i++) begin
            send_instr(OP_LUI, 1 + i, 0, 0, rand_bits(20) << 12, 32'd0);
            send_instr(OP_AUIPC, 1 + i, 0, 0, rand_bits(20) << 12, rand_bits(30) << 2);
        end
        test_done("lui_auipc");

        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d issued instructions never raised done_o", exp_q.size());
            errors++;
        end
        $display("Tests: %0d, instructions: %0d, checks: %0d, errors: %0d",
                 tests, issued, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns: done_o never arrived for the last instruction",
                 TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verification
hdl/exec_pkg.sv
hdl/wait_timer.sv
hdl/reg_file.sv
hdl/alu_branch.sv
hdl/load_store_unit.sv
hdl/data_ram.sv
hdl/exec_ctrl_fsm.sv
hdl/exec_top.sv
verification/exec_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f verilog.f --top-module exec_tb \
    -Mdir obj_dir -o exec_sim

./obj_dir/exec_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation FAILED: run ended without a result line"
    exit 1
fi
echo "Simulation PASSED"
